//--- hw/uart_rx_macros.svh
// oversampling points assume 16 baud ticks per bit; counters must hold a value of 15
`ifndef UART_RX_MACROS_SVH
`define UART_RX_MACROS_SVH

// ----------------------------------------------------------------------
// oversampling points, counted in baud ticks
// ----------------------------------------------------------------------
`define UART_RX_MID_START        8   // low ticks that confirm a start bit
`define UART_RX_SAMPLE_TICK      15  // data and parity sample point
`define UART_RX_STOP_CHECK_TICK  14  // stop bit judged here
`define UART_RX_WAIT_LIMIT       6   // max ticks waiting for idle line

// widths
`define UART_RX_CNT_W            4   // tick and bit counters
`define UART_RX_WB_ADR_W         2   // wishbone word address

// register map, word addresses
`define UART_RX_ADR_DATA         2'd0
`define UART_RX_ADR_STATUS       2'd1
`define UART_RX_ADR_FORMAT       2'd2

// 8 data bits, parity off, even
`define UART_RX_RESET_FORMAT     3'b100

`endif

//--- hw/uart_rx_pkg.sv
// frame union views assume at most 8 data bits plus one parity bit
`default_nettype none

package uart_rx_pkg;

  // frame format as held in the format register, msb first
  typedef struct packed {
    logic bit8;        // 1 = 8 data bits, 0 = 7
    logic parity_en;   // parity bit present
    logic odd_n_even;  // 1 = odd parity
  } rx_format_t;

  // received word, last sampled bit sits at the top of the active view
  typedef union packed {
    struct packed {
      logic       parity;
      logic [7:0] data;
    } b8;
    struct packed {
      logic       pad;    // unused in 7 bit mode
      logic       parity;
      logic [6:0] data;
    } b7;
  } rx_frame_u;

  typedef enum logic [1:0] {
    st_idle,
    st_data,
    st_stop,
    st_wait
  } rx_state_e;

endpackage

`default_nettype wire

//--- hw/rx_frame_if.sv
// no handshake: the register side must accept frame_done in the cycle it is raised
`default_nettype none

interface rx_frame_if;

  uart_rx_pkg::rx_format_t format;      // frame format from the registers
  logic                    frame_done;  // one clk pulse, frame word valid
  uart_rx_pkg::rx_frame_u  frame;       // raw received word
  logic                    parity_err;  // valid with frame_done
  logic                    framing_err; // one clk pulse at the stop check

  // register block side
  modport regs (
    output format,
    input  frame_done,
    input  frame,
    input  parity_err,
    input  framing_err
  );

  // receive engine side
  modport engine (
    input  format,
    output frame_done,
    output frame,
    output parity_err,
    output framing_err
  );

endinterface

`default_nettype wire

//--- hw/rx_majority_filter.sv
// rx must already be synchronised to clk; output lags the line by two baud ticks
`default_nettype none

module rx_majority_filter (
  input  logic clk,
  input  logic aresetn,
  input  logic baud_tick,
  input  logic rx,
  output logic rx_filtered
);

  logic [2:0] samples;  // newest sample in bit 2

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      samples <= 3'b111;  // idle line level
    end
    else if (baud_tick)
    begin
      samples <= {rx, samples[2:1]};
    end
  end

  // two of three vote, a single low tick never gets through
  assign rx_filtered = (samples[0] & samples[1]) |
                       (samples[1] & samples[2]) |
                       (samples[0] & samples[2]);

endmodule

`default_nettype wire

//--- hw/rx_frame_engine.sv
// frame length is latched at start confirmation; parity mode is taken live at frame end
`default_nettype none

`include "uart_rx_macros.svh"

module rx_frame_engine (
  input  logic        clk,
  input  logic        aresetn,
  input  logic        baud_tick,
  input  logic        rx_filtered,
  rx_frame_if.engine  fr
);

  uart_rx_pkg::rx_state_e state;

  logic [`UART_RX_CNT_W-1:0] tick_cnt;  // ticks within the current bit
  logic [`UART_RX_CNT_W-1:0] bit_cnt;   // bits sampled so far
  logic [`UART_RX_CNT_W-1:0] last_bit;  // data bits plus parity bit
  logic [8:0]                shift_q;   // received word
  logic                      par_acc;   // xor of every sampled bit

  logic start_ok;
  logic sample_en;

  assign start_ok  = baud_tick && (state == uart_rx_pkg::st_idle) &&
                     (tick_cnt == `UART_RX_MID_START);
  assign sample_en = baud_tick && (state == uart_rx_pkg::st_data) &&
                     (tick_cnt == `UART_RX_SAMPLE_TICK);

  // ----------------------------------------------------------------------
  // state machine and counters
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state          <= uart_rx_pkg::st_idle;
      tick_cnt       <= '0;
      bit_cnt        <= '0;
      last_bit       <= `UART_RX_CNT_W'(9);
      fr.frame_done  <= 1'b0;
      fr.parity_err  <= 1'b0;
      fr.framing_err <= 1'b0;
    end
    else
    begin
      fr.frame_done  <= 1'b0;  // pulses last one clk
      fr.framing_err <= 1'b0;
      if (baud_tick)
      begin
        case (state)
          uart_rx_pkg::st_idle:
          begin
            if (start_ok)
            begin
              state    <= uart_rx_pkg::st_data;
              tick_cnt <= '0;
              bit_cnt  <= '0;
              last_bit <= `UART_RX_CNT_W'(7 + fr.format.bit8 + fr.format.parity_en);
            end
            else if (rx_filtered)
            begin
              tick_cnt <= '0;  // low run broken, start over
            end
            else
            begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end

          uart_rx_pkg::st_data:
          begin
            tick_cnt <= tick_cnt + 1'b1;  // wraps every bit
            if (sample_en)
            begin
              bit_cnt <= bit_cnt + 1'b1;
            end
            if (bit_cnt == last_bit)
            begin
              // word complete, stop bit still to come
              state         <= uart_rx_pkg::st_stop;
              fr.frame_done <= 1'b1;
              fr.parity_err <= fr.format.parity_en & (par_acc ^ fr.format.odd_n_even);
            end
          end

          uart_rx_pkg::st_stop:
          begin
            tick_cnt <= tick_cnt + 1'b1;
            if (tick_cnt == `UART_RX_STOP_CHECK_TICK)
            begin
              fr.framing_err <= ~rx_filtered;
            end
            else if (tick_cnt == `UART_RX_SAMPLE_TICK)
            begin
              state <= uart_rx_pkg::st_wait;
            end
          end

          default:  // st_wait
          begin
            if (rx_filtered || (tick_cnt == `UART_RX_WAIT_LIMIT))
            begin
              state    <= uart_rx_pkg::st_idle;
              tick_cnt <= '0;
            end
            else
            begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // shift word and running parity
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (start_ok)
    begin
      shift_q <= '0;
      par_acc <= 1'b0;
    end
    else if (sample_en)
    begin
      par_acc <= par_acc ^ rx_filtered;
      // new bit enters at the top of the active view, lsb first on the line
      case (last_bit)
        `UART_RX_CNT_W'(7):
        begin
          shift_q[5:0] <= shift_q[6:1];
          shift_q[6]   <= rx_filtered;
        end
        `UART_RX_CNT_W'(8):
        begin
          shift_q[6:0] <= shift_q[7:1];
          shift_q[7]   <= rx_filtered;
        end
        default:
        begin
          shift_q <= {rx_filtered, shift_q[8:1]};
        end
      endcase
    end
  end

  assign fr.frame = uart_rx_pkg::rx_frame_u'(shift_q);

endmodule

`default_nettype wire

//--- hw/uart_rx_wb_regs.sv
// single-cycle wishbone classic slave; master must drop stb in the cycle it sees ack
`default_nettype none

`include "uart_rx_macros.svh"

module uart_rx_wb_regs (
  input  logic                         clk,
  input  logic                         aresetn,
  input  logic                         cyc,
  input  logic                         stb,
  input  logic                         we,
  input  logic [`UART_RX_WB_ADR_W-1:0] adr,
  input  logic [7:0]                   dat_w,
  output logic [7:0]                   dat_r,
  output logic                         ack,
  rx_frame_if.regs                     fr
);

  logic [7:0] rx_byte;
  logic       full;
  logic       overflow;
  logic       parity_flag;
  logic       framing_flag;

  logic access;   // request seen, side effects happen here
  logic rd_data;
  logic wr_status;
  logic wr_format;

  assign access    = cyc & stb & ~ack;
  assign rd_data   = access & ~we & (adr == `UART_RX_ADR_DATA);
  assign wr_status = access & we & (adr == `UART_RX_ADR_STATUS);
  assign wr_format = access & we & (adr == `UART_RX_ADR_FORMAT);

  // ----------------------------------------------------------------------
  // byte register and status flags
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      ack          <= 1'b0;
      rx_byte      <= '0;
      full         <= 1'b0;
      overflow     <= 1'b0;
      parity_flag  <= 1'b0;
      framing_flag <= 1'b0;
      fr.format    <= uart_rx_pkg::rx_format_t'(`UART_RX_RESET_FORMAT);
    end
    else
    begin
      ack <= access;

      if (rd_data)
      begin
        full     <= 1'b0;
        overflow <= 1'b0;
      end

      if (fr.frame_done)
      begin
        if (full && !rd_data)
        begin
          overflow <= 1'b1;  // held byte stays
        end
        else
        begin
          full    <= 1'b1;
          rx_byte <= fr.format.bit8 ? fr.frame.b8.data : {1'b0, fr.frame.b7.data};
        end
      end

      // a new error wins over a clear in the same cycle
      if (fr.frame_done && fr.parity_err)
      begin
        parity_flag <= 1'b1;
      end
      else if (wr_status && dat_w[2])
      begin
        parity_flag <= 1'b0;
      end

      if (fr.framing_err)
      begin
        framing_flag <= 1'b1;
      end
      else if (wr_status && dat_w[3])
      begin
        framing_flag <= 1'b0;
      end

      if (wr_format)
      begin
        fr.format <= uart_rx_pkg::rx_format_t'(dat_w[2:0]);
      end
    end
  end

  // read data, valid with ack
  always_ff @(posedge clk)
  begin
    if (access)
    begin
      case (adr)
        `UART_RX_ADR_DATA:   dat_r <= rx_byte;
        `UART_RX_ADR_STATUS: dat_r <= {4'b0, framing_flag, parity_flag, overflow, full};
        `UART_RX_ADR_FORMAT: dat_r <= {5'b0, fr.format};
        default:             dat_r <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/uart_rx_top.sv
// baud_tick must pulse for one clk, 16 times per bit; rx must be synchronous to clk
`default_nettype none

`include "uart_rx_macros.svh"

module uart_rx_top (
  input  logic                         clk,
  input  logic                         aresetn,
  input  logic                         baud_tick,
  input  logic                         rx,
  input  logic                         cyc,
  input  logic                         stb,
  input  logic                         we,
  input  logic [`UART_RX_WB_ADR_W-1:0] adr,
  input  logic [7:0]                   dat_w,
  output logic [7:0]                   dat_r,
  output logic                         ack
);

  logic rx_filtered;

  rx_frame_if fr ();  // engine to register block

  rx_majority_filter i_filter (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx          (rx),
    .rx_filtered (rx_filtered)
  );

  rx_frame_engine i_engine (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx_filtered (rx_filtered),
    .fr          (fr.engine)
  );

  uart_rx_wb_regs i_regs (
    .clk     (clk),
    .aresetn (aresetn),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .adr     (adr),
    .dat_w   (dat_w),
    .dat_r   (dat_r),
    .ack     (ack),
    .fr      (fr.regs)
  );

endmodule

`default_nettype wire

//--- verification/uart_rx_tb.sv
// baud_tick every 4 clks, so one bit lasts 64 clks; a frame is fully received one idle bit later
`default_nettype none

`include "uart_rx_macros.svh"

module uart_rx_tb;

  localparam int n_frames = 6 + 8 + 1 + 2 + 2;  // last two are the low pulses

  typedef struct packed {
    logic [1:0] kind;  // register address that was read
    logic [7:0] got;
    logic [7:0] exp;
  } result_t;

  logic                         clk = 1'b0;
  logic                         aresetn;
  logic                         baud_tick = 1'b0;
  logic                         rx;
  logic                         cyc;
  logic                         stb;
  logic                         we;
  logic [`UART_RX_WB_ADR_W-1:0] adr;
  logic [7:0]                   dat_w;
  logic [7:0]                   dat_r;
  logic                         ack;

  logic [1:0]  tick_div = 2'd0;
  logic [31:0] lfsr_state = 32'h1d09;
  result_t     result_q[$];
  int          mismatch_cnt = 0;
  int          other_cnt = 0;

  uart_rx_top i_dut (
    .clk       (clk),
    .aresetn   (aresetn),
    .baud_tick (baud_tick),
    .rx        (rx),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .dat_r     (dat_r),
    .ack       (ack)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    tick_div  <= tick_div + 2'd1;
    baud_tick <= (tick_div == 2'd3);  // one tick per 4 clks
  end

  // ----------------------------------------------------------------------
  // random data and expected results
  // ----------------------------------------------------------------------
  function automatic logic [7:0] random_byte();
    logic [7:0] b;
    int         i;
    b = 8'h00;
    for (i = 0; i < 8; i++)
    begin
      // taps 32 22 2 1
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      b = {b[6:0], lfsr_state[0]};
    end
    return b;
  endfunction

  // {status, byte} as the host should see it before reading the byte
  function automatic logic [11:0] expect_frame(input logic [7:0] data,
                                               input uart_rx_pkg::rx_format_t fmt,
                                               input logic bad_par, input logic bad_stop,
                                               input logic overrun);
    logic [7:0] exp_byte;
    logic [3:0] exp_status;
    exp_byte   = fmt.bit8 ? data : {1'b0, data[6:0]};
    exp_status = {bad_stop, fmt.parity_en & bad_par, overrun, 1'b1};
    return {exp_status, exp_byte};
  endfunction

  // ----------------------------------------------------------------------
  // compare tasks and the compare process
  // ----------------------------------------------------------------------
  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      mismatch_cnt++;
      $display("Mismatch dat_r byte: got 0x%h expected 0x%h", got, exp);
    end
  endtask

  task automatic check_status(input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp)
    begin
      mismatch_cnt++;
      $display("Mismatch dat_r status: got 0x%h expected 0x%h", got, exp);
    end
  endtask

  task automatic check_format(input uart_rx_pkg::rx_format_t got,
                              input uart_rx_pkg::rx_format_t exp);
    if (got !== exp)
    begin
      mismatch_cnt++;
      $display("Mismatch dat_r format: got 0x%h expected 0x%h", got, exp);
    end
  endtask

  always @(posedge clk)
  begin : compare_results
    result_t r;
    while (result_q.size() > 0)
    begin
      r = result_q.pop_front();
      case (r.kind)
        `UART_RX_ADR_DATA:   check_byte(r.got, r.exp);
        `UART_RX_ADR_STATUS: check_status(r.got[3:0], r.exp[3:0]);
        default:             check_format(uart_rx_pkg::rx_format_t'(r.got[2:0]),
                                          uart_rx_pkg::rx_format_t'(r.exp[2:0]));
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // bus and serial drivers
  // ----------------------------------------------------------------------
  task automatic wait_ack();
    int n;
    n = 0;
    @(posedge clk);
    while (!ack && n < 4)
    begin
      @(posedge clk);
      n++;
    end
    if (!ack)
    begin
      other_cnt++;
      $display("no ack within 4 cycles at address %0d", adr);
    end
    cyc <= 1'b0;  // stb drops in the cycle that sees ack
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= a;
    dat_w <= d;
    wait_ack();
  endtask

  task automatic read_expect(input logic [1:0] a, input logic [7:0] exp);
    result_t r;
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    wait_ack();
    r.kind = a;
    r.got  = dat_r;  // sampled in the ack cycle
    r.exp  = exp;
    result_q.push_back(r);
  endtask

  task automatic send_bit(input logic b);
    rx <= b;
    repeat (64) @(posedge clk);  // 16 ticks
  endtask

  task automatic send_frame(input logic [7:0] data, input uart_rx_pkg::rx_format_t fmt,
                            input logic bad_par, input logic bad_stop);
    logic par;
    int   i;
    par = 1'b0;
    send_bit(1'b0);  // start
    for (i = 0; i < (fmt.bit8 ? 8 : 7); i++)
    begin
      send_bit(data[i]);
      par = par ^ data[i];
    end
    if (fmt.parity_en)
    begin
      send_bit(par ^ fmt.odd_n_even ^ bad_par);
    end
    send_bit(~bad_stop);
    send_bit(1'b1);  // idle bit lets the engine return to idle
  endtask

  task automatic low_pulse(input int clks);
    rx <= 1'b0;
    repeat (clks) @(posedge clk);
    send_bit(1'b1);
    send_bit(1'b1);
  endtask

  task automatic run_frame(input logic [7:0] data, input uart_rx_pkg::rx_format_t fmt,
                           input logic bad_par, input logic bad_stop);
    logic [11:0] exp;
    exp = expect_frame(data, fmt, bad_par, bad_stop, 1'b0);
    send_frame(data, fmt, bad_par, bad_stop);
    read_expect(`UART_RX_ADR_STATUS, {4'b0, exp[11:8]});
    read_expect(`UART_RX_ADR_DATA, exp[7:0]);
    read_expect(`UART_RX_ADR_STATUS, {4'b0, exp[11:10], 2'b00});  // full gone
    if (exp[11:10] != 2'b00)
    begin
      bus_write(`UART_RX_ADR_STATUS, {4'b0, exp[11:10], 2'b00});  // write one to clear
      read_expect(`UART_RX_ADR_STATUS, 8'h00);
    end
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial
  begin : main
    uart_rx_pkg::rx_format_t f;
    logic [7:0]              d1;
    logic [7:0]              d2;
    logic [11:0]             exp;
    int                      i;
    aresetn <= 1'b0;
    rx      <= 1'b1;
    cyc     <= 1'b0;
    stb     <= 1'b0;
    we      <= 1'b0;
    adr     <= '0;
    dat_w   <= 8'h00;
    repeat (5) @(posedge clk);
    aresetn <= 1'b1;

    read_expect(`UART_RX_ADR_FORMAT, {5'b0, `UART_RX_RESET_FORMAT});
    f = uart_rx_pkg::rx_format_t'(`UART_RX_RESET_FORMAT);
    for (i = 0; i < 6; i++)
    begin
      run_frame(random_byte(), f, 1'b0, 1'b0);
    end

    // good then bad parity bit in each data width and parity sense
    for (i = 0; i < 4; i++)
    begin
      f.bit8       = i[1];
      f.parity_en  = 1'b1;
      f.odd_n_even = i[0];
      bus_write(`UART_RX_ADR_FORMAT, {5'b0, f});
      run_frame(random_byte(), f, 1'b0, 1'b0);
      run_frame(random_byte(), f, 1'b1, 1'b0);
    end

    f = uart_rx_pkg::rx_format_t'(`UART_RX_RESET_FORMAT);
    bus_write(`UART_RX_ADR_FORMAT, {5'b0, f});
    run_frame(random_byte(), f, 1'b0, 1'b1);  // stop bit low

    // overflow keeps the first byte
    d1  = random_byte();
    d2  = random_byte();
    if (d2 == d1)
    begin
      d2 = ~d1;  // second byte differs so a lost first byte shows
    end
    exp = expect_frame(d1, f, 1'b0, 1'b0, 1'b1);
    send_frame(d1, f, 1'b0, 1'b0);
    send_frame(d2, f, 1'b0, 1'b0);
    read_expect(`UART_RX_ADR_STATUS, {4'b0, exp[11:8]});
    read_expect(`UART_RX_ADR_DATA, exp[7:0]);
    read_expect(`UART_RX_ADR_STATUS, 8'h00);

    low_pulse(4);   // caught by a single tick sample
    read_expect(`UART_RX_ADR_STATUS, 8'h00);
    low_pulse(16);  // four low ticks are too short for a start bit
    read_expect(`UART_RX_ADR_STATUS, 8'h00);

    bus_write(`UART_RX_ADR_FORMAT, 8'h03);
    read_expect(`UART_RX_ADR_FORMAT, 8'h03);

    repeat (2) @(posedge clk);
    if (result_q.size() != 0)
    begin
      other_cnt++;
      $display("%0d read results were never compared", result_q.size());
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt + other_cnt == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial
  begin : watchdog
    #(n_frames * 12 * 64 * 20 + 2000 * 20);
    $display("timeout, the test sequence did not finish in time");
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt + 1);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- uart_rx_top.f
+incdir+hw
hw/uart_rx_pkg.sv
hw/rx_frame_if.sv
hw/rx_majority_filter.sv
hw/rx_frame_engine.sv
hw/uart_rx_wb_regs.sv
hw/uart_rx_top.sv
verification/uart_rx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f uart_rx_top.f --top-module uart_rx_tb -o uart_rx_sim
./obj_dir/uart_rx_sim | tee sim.log

if grep -qF '** FAIL **' sim.log; then
  exit 1
fi
